//--- project.f
common/cpu_pkg.sv
controller/controller.sv
design/bus_master.sv
design/register_file.sv
design/alu.sv
design/operand_select.sv
design/pc_unit.sv
design/cpu_core.sv
tests/tb_memory.sv
tests/cpu_core_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - common/cpu_pkg.sv
      - controller/controller.sv
      - design/bus_master.sv
      - design/register_file.sv
      - design/alu.sv
      - design/operand_select.sv
      - design/pc_unit.sv
      - design/cpu_core.sv
  - target: test
    files:
      - tests/tb_memory.sv
      - tests/cpu_core_tb.sv

//--- tests/cpu_core_tb.sv
module cpu_core_tb import cpu_pkg::*; ();

	typedef struct packed {
		logic [2:0]  test;
		logic [31:0] adr;
		logic [31:0] dat;
	} store_t;

	logic        clock;
	logic        reset;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	store_t      exp_stores [$];
	logic [31:0] exp_fetches [$];
	store_t      store_now;
	logic [31:0] fetch_now;
	int          errors [1:5];
	bit          reported [1:5];
	int          cycle_count;
	int          cycle_limit;
	bit          first_seen;
	bit          run_done;
	bit          timed_out;
	int          failed_tests;
	int          error_total;
	logic [31:0] r1;
	logic [31:0] r2;

	cpu_core i_cpu_core (
		.clock  (clock),
		.reset  (reset),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	tb_memory i_tb_memory (
		.clock  (clock),
		.reset  (reset),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	task automatic report_mismatch(int test, string signal, logic [31:0] expected,
		logic [31:0] actual);
		$display("[ERROR] %0t %s expected %h got %h", $time, signal, expected, actual);
		errors[test]++;
	endtask

	task automatic report_problem(int test, string what);
		$display("%0t test %0d: %s", $time, test, what);
		errors[test]++;
	endtask

	task automatic report_test(int test);
		string name;
		case (test)
			1: name = "reset and first fetch";
			2: name = "wishbone protocol";
			3: name = "register and immediate operations";
			4: name = "loads and addressing";
			default: name = "control flow";
		endcase
		reported[test] = 1'b1;
		$display("test %0d %s: %s, %0d errors", test, name,
			errors[test] == 0 ? "ok" : "failed", errors[test]);
	endtask

	task automatic expect_store(int test, logic [31:0] adr, logic [31:0] dat);
		store_t entry;
		entry.test = 3'(test);
		entry.adr = adr;
		entry.dat = dat;
		exp_stores.push_back(entry);
	endtask

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	idle_in_reset: assert property (@(posedge clock) reset |-> !wb_req.cyc && !wb_req.stb)
		else report_problem(1, "bus request active while reset is high");

	stb_needs_cyc: assert property (@(posedge clock) disable iff (reset)
		wb_req.stb |-> wb_req.cyc)
		else report_problem(2, "stb high without cyc");

	request_stable: assert property (@(posedge clock) disable iff (reset)
		wb_req.stb && !wb_rsp.ack |=> $stable(wb_req.adr) && $stable(wb_req.we)
			&& $stable(wb_req.dat_w) && $stable(wb_req.sel))
		else report_problem(2, "request changed while stb waited for ack");

	ack_ends_cycle: assert property (@(posedge clock) disable iff (reset)
		wb_req.cyc && wb_rsp.ack |=> !wb_req.cyc && !wb_req.stb)
		else report_problem(2, "cyc or stb still high the cycle after ack");

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
			timed_out = 1'b1;
		if (!reset && wb_req.cyc && !first_seen) begin
			first_seen = 1'b1;
			first_adr: assert (wb_req.adr == RESET_PC)
				else report_mismatch(1, "wb_req.adr", RESET_PC, wb_req.adr);
			first_read: assert (!wb_req.we)
				else report_problem(1, "first request is a write");
			report_test(1);
		end
		if (wb_req.cyc && wb_rsp.ack && !wb_req.we && i_cpu_core.phase == FETCH
			&& exp_fetches.size() != 0) begin
			fetch_now = exp_fetches.pop_front();
			fetch_order: assert (wb_req.adr == fetch_now)
				else report_mismatch(5, "wb_req.adr", fetch_now, wb_req.adr);
			if (exp_fetches.size() == 0) begin
				report_test(5);
				run_done = 1'b1;
			end
		end
		if (wb_req.cyc && wb_rsp.ack && wb_req.we) begin
			if (exp_stores.size() == 0) begin
				report_problem(4, $sformatf("unexpected store to %h", wb_req.adr));
			end else begin
				store_now = exp_stores.pop_front();
				store_adr: assert (wb_req.adr == store_now.adr)
					else report_mismatch(store_now.test, "wb_req.adr", store_now.adr,
						wb_req.adr);
				store_dat: assert (wb_req.dat_w == store_now.dat)
					else report_mismatch(store_now.test, "wb_req.dat_w", store_now.dat,
						wb_req.dat_w);
				store_sel: assert (wb_req.sel == 4'hf)
					else report_mismatch(store_now.test, "wb_req.sel", 32'hf, 32'(wb_req.sel));
				if (exp_stores.size() == 0 || exp_stores[0].test != store_now.test)
					report_test(store_now.test);
			end
		end
	end

	initial begin
		reset = 1'b0;
		r1 = {12'd0, 20'h12345};
		r2 = {{12{1'b1}}, 20'hfff00};
		expect_store(3, 32'h300, r1);
		expect_store(3, 32'h304, r2);
		expect_store(3, 32'h308, r1 + r2);
		expect_store(3, 32'h30c, r1 - r2);
		expect_store(3, 32'h310, r1 & r2);
		expect_store(3, 32'h314, r1 | r2);
		expect_store(3, 32'h318, r1 ^ r2);
		expect_store(3, 32'h31c, r2 >> 4);
		expect_store(3, 32'h320, r1 << 8);
		expect_store(3, 32'h324, {r1[7:0], r1[31:8]});
		expect_store(3, 32'h328, r1 + {{17{1'b1}}, 15'h7fff});
		expect_store(3, 32'h32c, r1 | {17'd0, 15'h4321});
		expect_store(3, 32'h330, r1 ^ {17'd0, 15'h7fff});
		// loaded words leave through indexed and immediate offsets
		expect_store(4, 32'h300 + (32'h10 << 2), 32'h0bad_f00d);
		expect_store(4, 32'h300 + (32'h10 << 3), 32'h1357_9bdf);
		expect_store(4, 32'h300 + (32'h30 << 2), 32'hcafe_0001);
		for (int a = 0; a <= 'h90; a += 4)
			exp_fetches.push_back(a);
		exp_fetches.push_back(32'h90 + (2 << 2));
		exp_fetches.push_back(32'h98 + 4);
		exp_fetches.push_back(32'h9c + (3 << 2));
		exp_fetches.push_back(32'ha8 + 4);
		exp_fetches.push_back(32'hac + (3 << 2));
		exp_fetches.push_back(32'hb8 - 4);
		exp_fetches.push_back(32'hb4 + (2 << 2));
		exp_fetches.push_back(32'hbc);
		exp_fetches.push_back(32'hbc);
		// five phases plus two accesses of up to 3 waits and 2 bus cycles each
		cycle_limit = exp_fetches.size() * 16 + 64;
		#1 reset = 1'b1;
		repeat (2) @(posedge clock);
		#1 reset = 1'b0;
		while (!run_done && !timed_out)
			@(posedge clock);
		if (timed_out)
			report_problem(5,
				$sformatf("program did not finish within %0d cycles", cycle_count));
		if (exp_stores.size() != 0)
			report_problem(exp_stores[0].test,
				$sformatf("%0d expected stores never happened", exp_stores.size()));
		report_test(2);
		for (int t = 1; t <= 5; t++) begin
			if (!reported[t])
				report_test(t);
			if (errors[t] != 0)
				failed_tests++;
			error_total += errors[t];
		end
		$display("%0d of 5 tests failed, %0d errors in total", failed_tests, error_total);
		if (error_total == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- tests/tb_memory.sv
module tb_memory import cpu_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp
);

	logic [31:0] mem [256];
	int          next_word;
	int unsigned wait_left;
	wb_req_t     req;

	function automatic logic [31:0] reg_op(base_sub_t sub, logic [4:0] rt, ra, rb);
		return {1'b0, TY_BASE, rt, ra, rb, 5'd0, sub};
	endfunction

	function automatic logic [31:0] imm_op(opcode_t op, logic [4:0] rt, ra, logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic logic [31:0] movi(logic [4:0] rt, logic [19:0] imm);
		return {1'b0, MOVI, rt, imm};
	endfunction

	function automatic logic [31:0] indexed(ls_sub_t sub, logic [4:0] rt, ra, rb, logic [1:0] sv);
		return {1'b0, TY_LS, rt, ra, rb, sv, sub};
	endfunction

	function automatic logic [31:0] branch(logic ne, logic [4:0] rt, ra, logic [13:0] offset);
		return {1'b0, TY_B, rt, ra, ne, offset};
	endfunction

	function automatic logic [31:0] jump(logic [23:0] offset);
		return {1'b0, JJ, 1'b0, offset};
	endfunction

	task automatic place(logic [31:0] word);
		mem[next_word] = word;
		next_word++;
	endtask

	initial begin
		// fill marks each word with its index
		for (int i = 0; i < 256; i++)
			mem[i] = 32'ha5a5_0000 ^ (i << 8) ^ i;
		mem[128] = 32'hcafe_0001;
		mem[129] = 32'h0bad_f00d;
		mem[131] = 32'h1357_9bdf;
		next_word = 0;
		place(movi(1, 20'h12345));
		place(movi(2, 20'hfff00));
		place(reg_op(ADD, 3, 1, 2));
		place(reg_op(SUB, 4, 1, 2));
		place(reg_op(AND, 5, 1, 2));
		place(reg_op(OR, 6, 1, 2));
		place(reg_op(XOR, 7, 1, 2));
		place(reg_op(SRLI, 8, 2, 4));
		place(reg_op(SLLI, 9, 1, 8));
		place(reg_op(ROTRI, 10, 1, 8));
		place(imm_op(ADDI, 11, 1, 15'h7fff));
		place(imm_op(ORI, 12, 1, 15'h4321));
		place(imm_op(XORI, 13, 1, 15'h7fff));
		place(movi(20, 20'h300));
		// r1 to r13 out to 0x300 upward
		for (int r = 1; r <= 13; r++)
			place(imm_op(SWI, 5'(r), 20, 15'(r - 1)));
		place(movi(21, 20'h200));
		place(imm_op(LWI, 14, 21, 15'd1));
		place(movi(22, 20'd3));
		place(indexed(LW, 15, 21, 22, 2'd2));
		place(indexed(LW, 16, 21, 0, 2'd0));
		place(movi(24, 20'h10));
		place(indexed(SW, 14, 20, 24, 2'd2));
		place(indexed(SW, 15, 20, 24, 2'd3));
		place(imm_op(SWI, 16, 20, 15'h30));
		// control flow from 0x90 where skipped words keep the fill
		place(branch(BEQ_BIT, 1, 1, 14'd2));
		next_word++;
		place(branch(BEQ_BIT, 2, 1, 14'd2));
		place(branch(BNE_BIT, 2, 1, 14'd3));
		next_word += 2;
		place(branch(BNE_BIT, 3, 3, 14'd5));
		place(jump(24'd3));
		next_word++;
		place(jump(24'd2));
		place(branch(BNE_BIT, 2, 1, 14'h3fff));
		place(jump(24'd0));
	end

	// the first draw seeds this process once
	initial begin
		wb_rsp = '0;
		wait_left = $urandom(27359) % 4;
		forever begin
			@(posedge clock);
			req = wb_req;
			#1;
			if (reset || wb_rsp.ack || !(req.cyc && req.stb)) begin
				wb_rsp.ack = 1'b0;
			end else if (wait_left != 0) begin
				wait_left--;
			end else begin
				if (req.we)
					mem[req.adr[9:2]] = req.dat_w;
				wb_rsp.dat_r = mem[req.adr[9:2]];
				wb_rsp.ack = 1'b1;
				wait_left = $urandom % 4;
			end
		end
	end

endmodule

//--- design/cpu_core.sv
module cpu_core import cpu_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	output wb_req_t wb_req,
	input  wb_rsp_t wb_rsp
);

	phase_t      phase;
	ctrl_t       ctrl;
	instr_u      instruction;
	logic        access_done;
	logic [31:0] load_data;
	logic [31:0] pc;
	logic [31:0] ra_data;
	logic [31:0] rb_data;
	logic [31:0] rt_data;
	logic [31:0] src2;
	logic [31:0] alu_result;
	logic        alu_zero;
	logic [31:0] write_data;

	controller i_controller (
		.clock       (clock),
		.reset       (reset),
		.instruction (instruction),
		.access_done (access_done),
		.phase       (phase),
		.ctrl        (ctrl)
	);

	// one port for fetches and data
	bus_master i_bus_master (
		.clock       (clock),
		.reset       (reset),
		.phase       (phase),
		.ctrl        (ctrl),
		.pc          (pc),
		.data_addr   (alu_result),
		.store_data  (rt_data),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.instruction (instruction),
		.load_data   (load_data),
		.access_done (access_done)
	);

	register_file i_register_file (
		.clock        (clock),
		.reset        (reset),
		.ra_addr      (instruction.base.ra),
		.rb_addr      (instruction.base.rb),
		.rt_addr      (instruction.base.rt),
		.write_enable (ctrl.reg_write),
		.write_data   (write_data),
		.ra_data      (ra_data),
		.rb_data      (rb_data),
		.rt_data      (rt_data)
	);

	alu i_alu (
		.op     (ctrl.alu_op),
		.src1   (ra_data),
		.src2   (src2),
		.result (alu_result),
		.zero   (alu_zero)
	);

	operand_select i_operand_select (
		.instruction (instruction),
		.ctrl        (ctrl),
		.rb_data     (rb_data),
		.rt_data     (rt_data),
		.alu_result  (alu_result),
		.load_data   (load_data),
		.src2        (src2),
		.write_data  (write_data)
	);

	pc_unit i_pc_unit (
		.clock       (clock),
		.reset       (reset),
		.instruction (instruction),
		.pc_sel      (ctrl.pc_sel),
		.alu_zero    (alu_zero),
		.update      (phase == WRITEBACK),
		.pc          (pc)
	);

endmodule

//--- design/pc_unit.sv
module pc_unit import cpu_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  instr_u      instruction,
	input  pc_sel_t     pc_sel,
	input  logic        alu_zero,
	input  logic        update,
	output logic [31:0] pc
);

	logic        taken;
	logic [31:0] pc_plus4;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic [31:0] pc_next;

	assign taken = (instruction.branch.sub == BEQ_BIT && alu_zero)
		|| (instruction.branch.sub == BNE_BIT && !alu_zero);

	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc + {{16{instruction.branch.imm14[13]}}, instruction.branch.imm14, 2'b00};
	assign jump_target = pc + {{6{instruction.jump.imm24[23]}}, instruction.jump.imm24, 2'b00};

	always_comb begin
		case (pc_sel)
			PC_14BIT: pc_next = taken ? branch_target : pc_plus4;
			PC_24BIT: pc_next = jump_target;
			default:  pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			pc <= RESET_PC;
		else if (update)
			pc <= pc_next;
	end

endmodule

//--- design/operand_select.sv
module operand_select import cpu_pkg::*; (
	input  instr_u      instruction,
	input  ctrl_t       ctrl,
	input  logic [31:0] rb_data,
	input  logic [31:0] rt_data,
	input  logic [31:0] alu_result,
	input  logic [31:0] load_data,
	output logic [31:0] src2,
	output logic [31:0] write_data
);

	logic [31:0] imm_value;

	always_comb begin
		case (ctrl.imm_ext)
			IMM_5BIT_ZE:  imm_value = {27'd0, instruction.base.rb};
			IMM_15BIT_SE: imm_value = {{17{instruction.imm.imm15[14]}}, instruction.imm.imm15};
			IMM_15BIT_ZE: imm_value = {17'd0, instruction.imm.imm15};
			IMM_20BIT_SE: imm_value = {{12{instruction.mov.imm20[19]}}, instruction.mov.imm20};
			default:      imm_value = '0;
		endcase
	end

	always_comb begin
		case (ctrl.src2_sel)
			RBDATA:  src2 = rb_data;
			IMM:     src2 = imm_value;
			// word offsets
			LSWI:    src2 = {15'd0, instruction.imm.imm15, 2'b00};
			LSW:     src2 = rb_data << instruction.ls.sv;
			BENX:    src2 = rt_data;
			default: src2 = '0;
		endcase
	end

	always_comb begin
		case (ctrl.wr_sel)
			ALURESULT: write_data = alu_result;
			IMMDATA:   write_data = imm_value;
			LWX:       write_data = load_data;
			default:   write_data = alu_result;
		endcase
	end

endmodule

//--- design/alu.sv
module alu import cpu_pkg::*; (
	input  alu_op_t     op,
	input  logic [31:0] src1,
	input  logic [31:0] src2,
	output logic [31:0] result,
	output logic        zero
);

	logic [4:0]  shamt;
	logic [63:0] rotated;

	assign shamt = src2[4:0];
	// low half of the doubled word is the rotate
	assign rotated = {src1, src1} >> shamt;

	always_comb begin
		case (op)
			ALU_ADD:  result = src1 + src2;
			ALU_SUB:  result = src1 - src2;
			ALU_AND:  result = src1 & src2;
			ALU_OR:   result = src1 | src2;
			ALU_XOR:  result = src1 ^ src2;
			ALU_SRL:  result = src1 >> shamt;
			ALU_SLL:  result = src1 << shamt;
			ALU_ROTR: result = rotated[31:0];
			default:  result = src1 + src2;
		endcase
	end

	// equality for branches after subtract
	assign zero = (result == 32'd0);

endmodule

//--- design/register_file.sv
module register_file (
	input  logic        clock,
	input  logic        reset,
	input  logic [4:0]  ra_addr,
	input  logic [4:0]  rb_addr,
	input  logic [4:0]  rt_addr,
	input  logic        write_enable,
	input  logic [31:0] write_data,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data,
	output logic [31:0] rt_data
);

	logic [31:0] regs [32];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (write_enable) begin
			regs[rt_addr] <= write_data;
		end
	end

	// rt port doubles as store data and branch compare
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

endmodule

//--- design/bus_master.sv
module bus_master import cpu_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  phase_t      phase,
	input  ctrl_t       ctrl,
	input  logic [31:0] pc,
	input  logic [31:0] data_addr,
	input  logic [31:0] store_data,
	output wb_req_t     wb_req,
	input  wb_rsp_t     wb_rsp,
	output instr_u      instruction,
	output logic [31:0] load_data,
	output logic        access_done
);

	logic fetch_phase;
	logic data_phase;

	assign fetch_phase = (phase == FETCH);
	assign data_phase = (phase == MEMACCESS) && (ctrl.mem_read || ctrl.mem_write);
	assign access_done = wb_req.cyc && wb_rsp.ack;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wb_req <= '0;
		end else if (access_done) begin
			wb_req.cyc <= 1'b0;
			wb_req.stb <= 1'b0;
		end else if (!wb_req.cyc && (fetch_phase || data_phase)) begin
			wb_req.cyc <= 1'b1;
			wb_req.stb <= 1'b1;
			wb_req.we <= data_phase && ctrl.mem_write;
			wb_req.adr <= fetch_phase ? pc : data_addr;
			wb_req.dat_w <= store_data;
			wb_req.sel <= 4'hf;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			instruction <= '0;
		else if (access_done && fetch_phase)
			instruction <= wb_rsp.dat_r;
	end

	always_ff @(posedge clock) begin
		if (access_done && data_phase && !wb_req.we)
			load_data <= wb_rsp.dat_r;
	end

	stb_within_cyc: assert property (@(posedge clock) disable iff (reset)
		wb_req.stb |-> wb_req.cyc)
		else $error("stb raised outside a bus cycle");

	request_held: assert property (@(posedge clock) disable iff (reset)
		wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr)
			&& $stable(wb_req.we) && $stable(wb_req.dat_w))
		else $error("request changed while waiting for ack");

endmodule

//--- controller/controller.sv
module controller import cpu_pkg::*; (
	input  logic   clock,
	input  logic   reset,
	input  instr_u instruction,
	input  logic   access_done,
	output phase_t phase,
	output ctrl_t  ctrl
);

	phase_t phase_next;
	ctrl_t  decoded;
	logic   mem_access;

	assign mem_access = decoded.mem_read | decoded.mem_write;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= FETCH;
		end else begin
			phase <= phase_next;
		end
	end

	always_comb begin
		phase_next = phase;
		case (phase)
			FETCH: begin
				if (access_done)
					phase_next = DECODE;
			end
			DECODE:    phase_next = EXECUTE;
			EXECUTE:   phase_next = MEMACCESS;
			MEMACCESS: begin
				// loads and stores wait for the bus
				if (!mem_access || access_done)
					phase_next = WRITEBACK;
			end
			WRITEBACK: phase_next = FETCH;
			default:   phase_next = FETCH;
		endcase
	end

	always_comb begin
		decoded = '0;
		decoded.pc_sel = PC_4;
		decoded.src2_sel = UNKNOWN;
		decoded.imm_ext = IMM_15BIT_ZE;
		decoded.wr_sel = ALURESULT;
		decoded.alu_op = ALU_ADD;
		case (instruction.base.opcode)
			TY_BASE: begin
				case (instruction.base.sub)
					ADD, SUB, AND, OR, XOR: begin
						decoded.src2_sel = RBDATA;
						decoded.reg_write = 1'b1;
					end
					SRLI, SLLI, ROTRI: begin
						decoded.src2_sel = IMM;
						decoded.imm_ext = IMM_5BIT_ZE;
						decoded.reg_write = 1'b1;
					end
					default: decoded.reg_write = 1'b0;
				endcase
				case (instruction.base.sub)
					SUB:     decoded.alu_op = ALU_SUB;
					AND:     decoded.alu_op = ALU_AND;
					OR:      decoded.alu_op = ALU_OR;
					XOR:     decoded.alu_op = ALU_XOR;
					SRLI:    decoded.alu_op = ALU_SRL;
					SLLI:    decoded.alu_op = ALU_SLL;
					ROTRI:   decoded.alu_op = ALU_ROTR;
					default: decoded.alu_op = ALU_ADD;
				endcase
			end
			ADDI, ORI, XORI: begin
				decoded.src2_sel = IMM;
				decoded.reg_write = 1'b1;
				decoded.imm_ext = (instruction.base.opcode == ADDI) ? IMM_15BIT_SE : IMM_15BIT_ZE;
				if (instruction.base.opcode == ORI)
					decoded.alu_op = ALU_OR;
				else if (instruction.base.opcode == XORI)
					decoded.alu_op = ALU_XOR;
			end
			MOVI: begin
				decoded.src2_sel = IMM;
				decoded.imm_ext = IMM_20BIT_SE;
				decoded.wr_sel = IMMDATA;
				decoded.reg_write = 1'b1;
			end
			LWI, SWI: begin
				decoded.src2_sel = LSWI;
				decoded.wr_sel = LWX;
				decoded.mem_read = (instruction.base.opcode == LWI);
				decoded.mem_write = (instruction.base.opcode == SWI);
				decoded.reg_write = (instruction.base.opcode == LWI);
			end
			TY_LS: begin
				if (instruction.ls.sub8 == LW || instruction.ls.sub8 == SW) begin
					decoded.src2_sel = LSW;
					decoded.wr_sel = LWX;
					decoded.mem_read = (instruction.ls.sub8 == LW);
					decoded.mem_write = (instruction.ls.sub8 == SW);
					decoded.reg_write = (instruction.ls.sub8 == LW);
				end
			end
			TY_B: begin
				// ra minus rt sets the zero flag for pc_unit
				decoded.pc_sel = PC_14BIT;
				decoded.src2_sel = BENX;
				decoded.alu_op = ALU_SUB;
			end
			JJ:      decoded.pc_sel = PC_24BIT;
			default: decoded.reg_write = 1'b0;
		endcase
	end

	// write strobe only on the writeback edge
	always_comb begin
		ctrl = decoded;
		ctrl.reg_write = decoded.reg_write && (phase == WRITEBACK);
	end

	phase_onehot: assert property (@(posedge clock) disable iff (reset) $onehot(phase))
		else $error("phase register is not one-hot");

endmodule

//--- common/cpu_pkg.sv
package cpu_pkg;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	typedef enum logic [5:0] {
		TY_BASE = 6'b100000,
		ADDI    = 6'b101000,
		ORI     = 6'b101100,
		XORI    = 6'b101011,
		MOVI    = 6'b100010,
		LWI     = 6'b000010,
		SWI     = 6'b001010,
		TY_LS   = 6'b011100,
		TY_B    = 6'b100110,
		JJ      = 6'b100100
	} opcode_t;

	typedef enum logic [4:0] {
		ADD   = 5'b00000,
		SUB   = 5'b00001,
		AND   = 5'b00010,
		XOR   = 5'b00011,
		OR    = 5'b00100,
		SLLI  = 5'b01000,
		SRLI  = 5'b01001,
		ROTRI = 5'b01011
	} base_sub_t;

	typedef enum logic [7:0] {
		LW = 8'b0000_0010,
		SW = 8'b0000_1010
	} ls_sub_t;

	localparam logic BEQ_BIT = 1'b0;
	localparam logic BNE_BIT = 1'b1;

	typedef struct packed {
		logic      zero;
		opcode_t   opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		// shift amount in shifts
		logic [4:0] rb;
		logic [4:0] rsvd;
		base_sub_t sub;
	} base_fmt_t;

	typedef struct packed {
		logic       zero;
		opcode_t    opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [14:0] imm15;
	} imm_fmt_t;

	typedef struct packed {
		logic        zero;
		opcode_t     opcode;
		logic [4:0]  rt;
		logic [19:0] imm20;
	} mov_fmt_t;

	typedef struct packed {
		logic       zero;
		opcode_t    opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [1:0] sv;
		ls_sub_t    sub8;
	} ls_fmt_t;

	typedef struct packed {
		logic        zero;
		opcode_t     opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic        sub;
		logic [13:0] imm14;
	} branch_fmt_t;

	typedef struct packed {
		logic        zero;
		opcode_t     opcode;
		logic        rsvd;
		logic [23:0] imm24;
	} jump_fmt_t;

	typedef union packed {
		base_fmt_t   base;
		imm_fmt_t    imm;
		mov_fmt_t    mov;
		ls_fmt_t     ls;
		branch_fmt_t branch;
		jump_fmt_t   jump;
	} instr_u;

	typedef enum logic [1:0] {
		PC_4     = 2'd0,
		PC_14BIT = 2'd1,
		PC_24BIT = 2'd2
	} pc_sel_t;

	typedef enum logic [2:0] {
		RBDATA  = 3'd0,
		IMM     = 3'd1,
		LSWI    = 3'd2,
		LSW     = 3'd3,
		BENX    = 3'd4,
		UNKNOWN = 3'd7
	} src2_sel_t;

	typedef enum logic [1:0] {
		IMM_5BIT_ZE  = 2'd0,
		IMM_15BIT_SE = 2'd1,
		IMM_15BIT_ZE = 2'd2,
		IMM_20BIT_SE = 2'd3
	} imm_ext_t;

	typedef enum logic [1:0] {
		ALURESULT = 2'd0,
		IMMDATA   = 2'd1,
		LWX       = 2'd2
	} wr_sel_t;

	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_OR   = 3'd3,
		ALU_XOR  = 3'd4,
		ALU_SRL  = 3'd5,
		ALU_SLL  = 3'd6,
		ALU_ROTR = 3'd7
	} alu_op_t;

	typedef struct packed {
		pc_sel_t   pc_sel;
		src2_sel_t src2_sel;
		imm_ext_t  imm_ext;
		wr_sel_t   wr_sel;
		alu_op_t   alu_op;
		logic      mem_read;
		logic      mem_write;
		logic      reg_write;
	} ctrl_t;

	typedef enum logic [4:0] {
		FETCH     = 5'b00001,
		DECODE    = 5'b00010,
		EXECUTE   = 5'b00100,
		MEMACCESS = 5'b01000,
		WRITEBACK = 5'b10000
	} phase_t;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [31:0] adr;
		logic [31:0] dat_w;
		logic [3:0]  sel;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat_r;
	} wb_rsp_t;

endpackage
